// ==== include/dbus_config.svh ====
`ifndef DBUS_CONFIG_SVH
`define DBUS_CONFIG_SVH

// Data and address width
`define XLEN 32

// Byte lanes per word
`define MASK_W 4

// Data memory size in words (4 KiB)
`define DMEM_DEPTH 1024
`define DMEM_INDEX_W $clog2(`DMEM_DEPTH)

// Region numbers, upper half of the address
`define DMEM_REGION 0
`define GPIO_REGION 1

// GPIO register byte offsets
`define GPIO_OUT_OFFSET 0
`define GPIO_IN_OFFSET  4

`endif

// ==== source/dbus_pkg.sv ====
`include "dbus_config.svh"

package dbus_pkg;

  // Access width as requested by the core
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } access_size_e;

  // Target picked by the address decoder
  typedef enum logic [1:0] {
    tgt_none = 2'b00,
    tgt_dmem = 2'b01,
    tgt_gpio = 2'b10
  } target_sel_e;

  // Byte address, seen whole or as region and offset
  typedef union packed {
    logic [`XLEN-1:0] full;
    struct packed {
      logic [`XLEN/2-1:0] region;
      logic [`XLEN/2-1:0] offset;
    } split;
  } dbus_addr_u;

endpackage : dbus_pkg

// ==== source/lsu_align.sv ====
`timescale 1ns/10ps
`include "dbus_config.svh"

module lsu_align import dbus_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,

  // Core side
  input  logic               req,
  input  logic               wr,
  input  access_size_e       size,
  input  logic               is_unsigned,
  input  logic [`XLEN-1:0]   addr,
  input  logic [`XLEN-1:0]   data_wr,
  output logic               ack,
  output logic               err,
  output logic [`XLEN-1:0]   data_rd,

  // Inner bus toward the decoder
  output logic               bus_req,
  output logic               bus_wr,
  output logic [`XLEN-1:0]   bus_addr,
  output logic [`MASK_W-1:0] bus_mask,
  output logic [`XLEN-1:0]   bus_wdata,
  input  logic               bus_ack,
  input  logic               bus_err,
  input  logic [`XLEN-1:0]   bus_rdata
);

  dbus_addr_u         addr_u;
  logic               misaligned;
  logic [`MASK_W-1:0] lane_mask;

  // Return path record, one entry
  access_size_e       size_q;
  logic               unsigned_q;
  logic [1:0]         lane_q;
  logic               misal_q;
  logic [`XLEN-1:0]   shifted;

  assign addr_u = addr;

  always_comb begin
    case (size)
      size_half: misaligned = addr_u.full[0];
      size_word: misaligned = |addr_u.full[1:0];
      default:   misaligned = 1'b0;
    endcase
  end

  // Lanes touched by the access
  always_comb begin
    case (size)
      size_byte: lane_mask = 4'b0001 << addr_u.full[1:0];
      size_half: lane_mask = 4'b0011 << {addr_u.full[1], 1'b0};
      default:   lane_mask = 4'b1111;
    endcase
  end

  // Store data copied onto every lane, the mask picks the right ones
  always_comb begin
    case (size)
      size_byte: bus_wdata = {4{data_wr[7:0]}};
      size_half: bus_wdata = {2{data_wr[15:0]}};
      default:   bus_wdata = data_wr;
    endcase
  end

  assign bus_req  = req & ~misaligned;   // Misaligned never reaches the bus
  assign bus_wr   = wr;
  assign bus_addr = addr_u.full;
  assign bus_mask = lane_mask;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      misal_q <= 1'b0;
    end else begin
      misal_q <= req & misaligned;
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      size_q     <= size;
      unsigned_q <= is_unsigned;
      lane_q     <= addr_u.full[1:0];
    end
  end

  // Bring the addressed lanes down to bit 0
  assign shifted = bus_rdata >> {lane_q, 3'b000};

  // Decoder returns zero except on a good read
  always_comb begin
    case (size_q)
      size_byte: data_rd = unsigned_q ? {{(`XLEN-8){1'b0}}, shifted[7:0]}
                                      : {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
      size_half: data_rd = unsigned_q ? {{(`XLEN-16){1'b0}}, shifted[15:0]}
                                      : {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
      default:   data_rd = bus_rdata;
    endcase
  end

  assign ack = bus_ack | misal_q;   // Only one of the two can be set
  assign err = bus_err | misal_q;

endmodule : lsu_align

// ==== source/dbus_decoder.sv ====
`timescale 1ns/10ps
`include "dbus_config.svh"

module dbus_decoder import dbus_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,

  // Inner bus from the alignment unit
  input  logic                     bus_req,
  input  logic                     bus_wr,
  input  logic [`XLEN-1:0]         bus_addr,
  input  logic [`MASK_W-1:0]       bus_mask,
  input  logic [`XLEN-1:0]         bus_wdata,
  output logic                     bus_ack,
  output logic                     bus_err,
  output logic [`XLEN-1:0]         bus_rdata,

  // Data memory
  output logic                     dmem_sel,
  output logic                     dmem_wr,
  output logic [`DMEM_INDEX_W-1:0] dmem_index,
  input  logic [`XLEN-1:0]         dmem_rdata,

  // GPIO block
  output logic                     gpio_sel,
  output logic                     gpio_wr,
  output logic [`XLEN/2-1:0]       gpio_offset,
  input  logic [`XLEN-1:0]         gpio_rdata,

  // Shared by both targets
  output logic [`MASK_W-1:0]       tgt_mask,
  output logic [`XLEN-1:0]         tgt_wdata
);

  dbus_addr_u  addr_u;
  target_sel_e tgt;
  target_sel_e rd_sel_q;
  logic        ack_q;
  logic        unmapped_q;

  assign addr_u = bus_addr;

  always_comb begin
    tgt = tgt_none;
    if (addr_u.split.region == `DMEM_REGION && addr_u.split.offset < `DMEM_DEPTH * 4) begin
      tgt = tgt_dmem;
    end else if (addr_u.split.region == `GPIO_REGION &&
                 (addr_u.split.offset == `GPIO_OUT_OFFSET ||
                  addr_u.split.offset == `GPIO_IN_OFFSET)) begin
      tgt = tgt_gpio;
    end
  end

  assign dmem_sel    = bus_req & (tgt == tgt_dmem);
  assign dmem_wr     = bus_wr;
  assign dmem_index  = addr_u.split.offset[`DMEM_INDEX_W+1:2];   // Word index
  assign gpio_sel    = bus_req & (tgt == tgt_gpio);
  assign gpio_wr     = bus_wr;
  assign gpio_offset = addr_u.split.offset;
  assign tgt_mask    = bus_mask;
  assign tgt_wdata   = bus_wdata;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      ack_q      <= 1'b0;
      unmapped_q <= 1'b0;
      rd_sel_q   <= tgt_none;
    end else begin
      ack_q      <= bus_req;
      unmapped_q <= bus_req & (tgt == tgt_none);
      rd_sel_q   <= (bus_req && !bus_wr) ? tgt : tgt_none;   // Writes return no data
    end
  end

  assign bus_ack = ack_q;
  assign bus_err = unmapped_q;

  always_comb begin
    case (rd_sel_q)
      tgt_dmem: bus_rdata = dmem_rdata;
      tgt_gpio: bus_rdata = gpio_rdata;
      default:  bus_rdata = '0;
    endcase
  end

endmodule : dbus_decoder

// ==== source/dmem.sv ====
`timescale 1ns/10ps
`include "dbus_config.svh"

module dmem (
  input  logic                     clk,

  // Target bus from the decoder
  input  logic                     dmem_sel,
  input  logic                     dmem_wr,
  input  logic [`DMEM_INDEX_W-1:0] dmem_index,
  input  logic [`MASK_W-1:0]       tgt_mask,
  input  logic [`XLEN-1:0]         tgt_wdata,
  output logic [`XLEN-1:0]         dmem_rdata
);

  // Word organised storage
  logic [`XLEN-1:0] mem [`DMEM_DEPTH];

  logic             wr_en;
  logic             rd_en;

  assign wr_en = dmem_sel & dmem_wr;
  assign rd_en = dmem_sel & ~dmem_wr;

  // Byte masked store
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < `MASK_W; b++) begin
        if (tgt_mask[b]) begin
          mem[dmem_index][b*8 +: 8] <= tgt_wdata[b*8 +: 8];
        end
      end
    end
  end

  // Registered read, one cycle after select
  always_ff @(posedge clk) begin
    if (rd_en) begin
      dmem_rdata <= mem[dmem_index];
    end
  end

endmodule : dmem

// ==== source/gpio_regs.sv ====
`timescale 1ns/10ps
`include "dbus_config.svh"

module gpio_regs (
  input  logic               clk,
  input  logic               rst_n,

  // Target bus from the decoder
  input  logic               gpio_sel,
  input  logic               gpio_wr,
  input  logic [`XLEN/2-1:0] gpio_offset,
  input  logic [`MASK_W-1:0] tgt_mask,
  input  logic [`XLEN-1:0]   tgt_wdata,
  output logic [`XLEN-1:0]   gpio_rdata,

  // Pins
  input  logic [`XLEN-1:0]   gpio_in,
  output logic [`XLEN-1:0]   gpio_out
);

  logic [`XLEN-1:0] out_q;
  logic [`XLEN-1:0] in_meta_q;
  logic [`XLEN-1:0] in_sync_q;
  logic             out_hit;

  // Input register has no write path
  assign out_hit = gpio_sel & gpio_wr & (gpio_offset == `GPIO_OUT_OFFSET);

  always_ff @(posedge clk) begin
    if (rst_n) begin
      out_q <= '0;
    end else if (out_hit) begin
      for (int b = 0; b < `MASK_W; b++) begin
        if (tgt_mask[b]) begin
          out_q[b*8 +: 8] <= tgt_wdata[b*8 +: 8];
        end
      end
    end
  end

  // Two flop synchroniser on the pins
  always_ff @(posedge clk) begin
    in_meta_q <= gpio_in;
    in_sync_q <= in_meta_q;
  end

  always_ff @(posedge clk) begin
    if (gpio_sel && !gpio_wr) begin
      case (gpio_offset)
        `GPIO_OUT_OFFSET: gpio_rdata <= out_q;
        `GPIO_IN_OFFSET:  gpio_rdata <= in_sync_q;
        default:          gpio_rdata <= '0;
      endcase
    end
  end

  assign gpio_out = out_q;

endmodule : gpio_regs

// ==== source/dbus_top.sv ====
`timescale 1ns/10ps
`include "dbus_config.svh"

module dbus_top import dbus_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,

  // Core side
  input  logic             req,
  input  logic             wr,
  input  access_size_e     size,
  input  logic             is_unsigned,
  input  logic [`XLEN-1:0] addr,
  input  logic [`XLEN-1:0] data_wr,
  output logic             ack,
  output logic             err,
  output logic [`XLEN-1:0] data_rd,

  // Pins
  input  logic [`XLEN-1:0] gpio_in,
  output logic [`XLEN-1:0] gpio_out
);

  // Inner bus
  logic                     bus_req;
  logic                     bus_wr;
  logic [`XLEN-1:0]         bus_addr;
  logic [`MASK_W-1:0]       bus_mask;
  logic [`XLEN-1:0]         bus_wdata;
  logic                     bus_ack;
  logic                     bus_err;
  logic [`XLEN-1:0]         bus_rdata;

  // Target buses
  logic                     dmem_sel;
  logic                     dmem_wr;
  logic [`DMEM_INDEX_W-1:0] dmem_index;
  logic [`XLEN-1:0]         dmem_rdata;
  logic                     gpio_sel;
  logic                     gpio_wr;
  logic [`XLEN/2-1:0]       gpio_offset;
  logic [`XLEN-1:0]         gpio_rdata;
  logic [`MASK_W-1:0]       tgt_mask;
  logic [`XLEN-1:0]         tgt_wdata;

  lsu_align lsu_align_i (
    .clk, .rst_n,
    .req, .wr, .size, .is_unsigned, .addr, .data_wr,
    .ack, .err, .data_rd,
    .bus_req, .bus_wr, .bus_addr, .bus_mask, .bus_wdata,
    .bus_ack, .bus_err, .bus_rdata
  );

  // Decoder picks a target_sel_e, tgt_dmem goes to dmem and tgt_gpio to gpio_regs
  dbus_decoder dbus_decoder_i (
    .clk, .rst_n,
    .bus_req, .bus_wr, .bus_addr, .bus_mask, .bus_wdata,
    .bus_ack, .bus_err, .bus_rdata,
    .dmem_sel, .dmem_wr, .dmem_index, .dmem_rdata,
    .gpio_sel, .gpio_wr, .gpio_offset, .gpio_rdata,
    .tgt_mask, .tgt_wdata
  );

  dmem dmem_i (
    .clk,
    .dmem_sel, .dmem_wr, .dmem_index, .tgt_mask, .tgt_wdata,
    .dmem_rdata
  );

  gpio_regs gpio_regs_i (
    .clk, .rst_n,
    .gpio_sel, .gpio_wr, .gpio_offset, .tgt_mask, .tgt_wdata,
    .gpio_rdata,
    .gpio_in, .gpio_out
  );

endmodule : dbus_top

// ==== testbench/dbus_tb.sv ====
`timescale 1ns/10ps
`include "dbus_config.svh"

module dbus_tb import dbus_pkg::*; ();

  logic             clk;
  logic             rst_n;
  logic             req;
  logic             wr;
  access_size_e     size;
  logic             is_unsigned;
  logic [`XLEN-1:0] addr;
  logic [`XLEN-1:0] data_wr;
  logic             ack;
  logic             err;
  logic [`XLEN-1:0] data_rd;
  logic [`XLEN-1:0] gpio_in;
  logic [`XLEN-1:0] gpio_out;

  // Stimulus table, one slot per cycle
  string            tbl_name[$];
  logic             tbl_req[$];
  logic             tbl_wr[$];
  access_size_e     tbl_size[$];
  logic             tbl_uns[$];
  logic [`XLEN-1:0] tbl_addr[$];
  logic [`XLEN-1:0] tbl_wdata[$];
  logic [`XLEN-1:0] tbl_exp_data[$];
  logic             tbl_exp_err[$];

  integer           seed = 32'hb8f8;
  int               value_errors = 0;
  int               handshake_errors = 0;
  logic             table_ready = 1'b0;

  dbus_top dut_i (
    .clk, .rst_n,
    .req, .wr, .size, .is_unsigned, .addr, .data_wr,
    .ack, .err, .data_rd,
    .gpio_in, .gpio_out
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic add_access(input string name, input logic w, input access_size_e sz,
                            input logic uns, input logic [`XLEN-1:0] a,
                            input logic [`XLEN-1:0] d, input logic [`XLEN-1:0] exp_d,
                            input logic exp_e);
    tbl_name.push_back(name);
    tbl_req.push_back(1'b1);
    tbl_wr.push_back(w);
    tbl_size.push_back(sz);
    tbl_uns.push_back(uns);
    tbl_addr.push_back(a);
    tbl_wdata.push_back(d);
    tbl_exp_data.push_back(exp_d);
    tbl_exp_err.push_back(exp_e);
  endtask

  task automatic add_idle();
    add_access("idle", 1'b0, size_byte, 1'b0, '0, '0, '0, 1'b0);
    tbl_req[tbl_req.size()-1] = 1'b0;
  endtask

  task automatic build_table();
    // Word store and back-to-back loads
    add_access("sw_0x10", 1, size_word, 0, 32'h0000_0010, 32'h1234_5678, 32'h0, 0);
    add_access("sw_0x20", 1, size_word, 0, 32'h0000_0020, 32'hCAFE_F00D, 32'h0, 0);
    add_access("sw_0x00", 1, size_word, 0, 32'h0000_0000, 32'h0BAD_CAFE, 32'h0, 0);
    add_access("lw_0x10", 0, size_word, 0, 32'h0000_0010, 32'h0, 32'h1234_5678, 0);
    add_access("lw_0x20", 0, size_word, 0, 32'h0000_0020, 32'h0, 32'hCAFE_F00D, 0);
    // Lane merges, only masked bytes change
    add_access("sw_0x30", 1, size_word, 0, 32'h0000_0030, 32'h0000_0000, 32'h0, 0);
    add_access("sb_0x31", 1, size_byte, 0, 32'h0000_0031, 32'hFFFF_FFAA, 32'h0, 0);
    add_access("sh_0x32", 1, size_half, 0, 32'h0000_0032, 32'h1234_BEEF, 32'h0, 0);
    add_access("lw_0x30", 0, size_word, 0, 32'h0000_0030, 32'h0, 32'hBEEF_AA00, 0);
    add_access("sw_0x34", 1, size_word, 0, 32'h0000_0034, 32'h1111_1111, 32'h0, 0);
    add_access("sh_0x34", 1, size_half, 0, 32'h0000_0034, 32'hFFFF_8765, 32'h0, 0);
    add_access("sb_0x36", 1, size_byte, 0, 32'h0000_0036, 32'h7777_7744, 32'h0, 0);
    add_access("sb_0x37", 1, size_byte, 0, 32'h0000_0037, 32'h0000_009C, 32'h0, 0);
    add_access("lw_0x34", 0, size_word, 0, 32'h0000_0034, 32'h0, 32'h9C44_8765, 0);
    // Sign and zero extension
    add_access("lb_0x31", 0, size_byte, 0, 32'h0000_0031, 32'h0, 32'hFFFF_FFAA, 0);
    add_access("lbu_0x31", 0, size_byte, 1, 32'h0000_0031, 32'h0, 32'h0000_00AA, 0);
    add_access("lh_0x32", 0, size_half, 0, 32'h0000_0032, 32'h0, 32'hFFFF_BEEF, 0);
    add_access("lhu_0x32", 0, size_half, 1, 32'h0000_0032, 32'h0, 32'h0000_BEEF, 0);
    add_access("lh_0x34", 0, size_half, 0, 32'h0000_0034, 32'h0, 32'hFFFF_8765, 0);
    add_access("lb_0x37", 0, size_byte, 0, 32'h0000_0037, 32'h0, 32'hFFFF_FF9C, 0);
    add_access("lbu_0x36", 0, size_byte, 1, 32'h0000_0036, 32'h0, 32'h0000_0044, 0);
    add_access("lb_0x30", 0, size_byte, 0, 32'h0000_0030, 32'h0, 32'h0000_0000, 0);
    // Misaligned, memory must stay as it was
    add_access("sh_odd", 1, size_half, 0, 32'h0000_0011, 32'h0000_DEAD, 32'h0, 1);
    add_access("sw_unal", 1, size_word, 0, 32'h0000_0012, 32'hFFFF_FFFF, 32'h0, 1);
    add_access("lw_unal", 0, size_word, 0, 32'h0000_0013, 32'h0, 32'h0, 1);
    add_access("lh_odd", 0, size_half, 0, 32'h0000_0021, 32'h0, 32'h0, 1);
    add_access("lw_0x10_kept", 0, size_word, 0, 32'h0000_0010, 32'h0, 32'h1234_5678, 0);
    // Unmapped space
    add_access("lw_region2", 0, size_word, 0, 32'h0002_0000, 32'h0, 32'h0, 1);
    add_access("sw_dmem_4k", 1, size_word, 0, 32'h0000_1000, 32'h0000_5555, 32'h0, 1);
    add_access("lw_dmem_4k", 0, size_word, 0, 32'h0000_1000, 32'h0, 32'h0, 1);
    add_access("lw_0x00_kept", 0, size_word, 0, 32'h0000_0000, 32'h0, 32'h0BAD_CAFE, 0);
    add_access("lw_gpio_0x8", 0, size_word, 0, 32'h0001_0008, 32'h0, 32'h0, 1);
    // GPIO output register
    add_access("sw_gpio_out", 1, size_word, 0, 32'h0001_0000, 32'hA5A5_0F0F, 32'h0, 0);
    add_access("sb_gpio_out", 1, size_byte, 0, 32'h0001_0000, 32'h0000_003C, 32'h0, 0);
    add_access("sw_gpio_in", 1, size_word, 0, 32'h0001_0004, 32'hFFFF_FFFF, 32'h0, 0);
    add_access("lw_gpio_out", 0, size_word, 0, 32'h0001_0000, 32'h0, 32'hA5A5_0F3C, 0);
    add_access("lh_gpio_out", 0, size_half, 0, 32'h0001_0000, 32'h0, 32'h0000_0F3C, 0);
    repeat (4) add_idle();
    add_access("lw_gpio_in", 0, size_word, 0, 32'h0001_0004, 32'h0, gpio_in, 0);
  endtask

  task automatic drive_entry(input int i);
    req         = tbl_req[i];
    wr          = tbl_wr[i];
    size        = tbl_size[i];
    is_unsigned = tbl_uns[i];
    addr        = tbl_addr[i];
    data_wr     = tbl_wdata[i];
  endtask

  // Response of entry i is on the ports during its ack cycle
  task automatic check_response(input int i);
    if (tbl_req[i]) begin
      assert (ack === 1'b1) else begin
        $display("ERROR: %s got no acknowledge one cycle after its request", tbl_name[i]);
        handshake_errors++;
      end
      assert (err === tbl_exp_err[i]) else begin
        $display("FAILED %s err expected %0b actual %0b", tbl_name[i], tbl_exp_err[i], err);
        value_errors++;
      end
      assert (data_rd === tbl_exp_data[i]) else begin
        $display("FAILED %s data expected %08h actual %08h", tbl_name[i],
                 tbl_exp_data[i], data_rd);
        value_errors++;
      end
    end else begin
      assert (ack === 1'b0) else begin
        $display("ERROR: acknowledge seen in an idle cycle after %s", tbl_name[i]);
        handshake_errors++;
      end
    end
  endtask

  initial begin
    int n;
    rst_n       = 1'b1;   // Reset is active high
    req         = 1'b0;
    wr          = 1'b0;
    size        = size_byte;
    is_unsigned = 1'b0;
    addr        = '0;
    data_wr     = '0;
    gpio_in     = $random(seed);
    build_table();
    n = tbl_name.size();
    table_ready = 1'b1;

    repeat (16) @(posedge clk);
    #2 rst_n = 1'b0;

    for (int i = 0; i <= n; i++) begin
      @(posedge clk);
      #2;
      if (i > 0) check_response(i - 1);
      if (i < n) begin
        drive_entry(i);
      end else begin
        req = 1'b0;
      end
    end

    assert (gpio_out === 32'hA5A5_0F3C) else begin
      $display("FAILED gpio_out_pins expected %08h actual %08h", 32'hA5A5_0F3C, gpio_out);
      value_errors++;
    end

    $display("Summary: %0d value errors, %0d handshake errors", value_errors,
             handshake_errors);
    if (value_errors == 0 && handshake_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    int limit_ns;
    wait (table_ready);
    limit_ns = (tbl_name.size() + 16 + 20) * 40;
    #(limit_ns);
    $display("Watchdog: run did not finish within %0d ns", limit_ns);
    $display("Regression failed");
    $finish;
  end

endmodule : dbus_tb

// ==== verilog.f ====
+incdir+include
source/dbus_pkg.sv
source/lsu_align.sv
source/dbus_decoder.sv
source/dmem.sv
source/gpio_regs.sv
source/dbus_top.sv
testbench/dbus_tb.sv
